//--- list.f
common/qbu_frame_pkg.sv
common/qbu_verify_pkg.sv
source/verify_frame_detect.sv
verify/verify_timer.sv
verify/verify_fsm.sv
source/qbu_verify_top.sv
dv/tb_qbu_verify.sv

//--- Bender.yml
package:
  name: qbu_verify

sources:
  - common/qbu_frame_pkg.sv
  - common/qbu_verify_pkg.sv
  - source/verify_frame_detect.sv
  - verify/verify_timer.sv
  - verify/verify_fsm.sv
  - source/qbu_verify_top.sv
  - target: test
    files:
      - dv/tb_qbu_verify.sv

//--- dv/tb_qbu_verify.sv
// testbench for the frame preemption verify handshake
// frame stimulus, cycle reference model, output assertions, watchdog

`default_nettype none

module tb_qbu_verify
    import qbu_verify_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CYCLES_PER_MS = 125 * 1000;
    // five wait intervals plus frame traffic, 20 percent margin, 4 ns per cycle
    localparam int WATCHDOG_NS = (5 * CYCLES_PER_MS + 20000) * 4 * 12 / 10;

    logic        i_clk = 1'b0;
    logic        i_rst;
    logic [7:0]  i_v_rx_data;
    logic        i_v_rx_last;
    logic        i_v_rx_valid;
    logic [7:0]  i_r_rx_data;
    logic        i_r_rx_last;
    logic        i_r_rx_valid;
    logic        i_verify_enabled;
    logic        i_start_verify;
    logic        i_clear_verify;
    logic [15:0] i_verify_time;
    logic        i_verify_time_vld;
    logic        o_verify_rx_valid;
    logic        o_response_rx_valid;
    logic        o_tx_valid;
    logic        o_tx_last;
    logic [7:0]  o_tx_smd;
    logic        o_verify_done;
    logic        o_verify_succ;
    logic        o_preempt_enable;
    logic [15:0] o_err_verify_cnt;

    // stimulus marks the last beat of a qualifying frame per stream
    logic        v_frame_good;
    logic        r_frame_good;

    integer      seed = 32'h6d237829;
    int          mismatch_errs = 0;
    int          other_errs = 0;
    int          bursts_seen = 0;
    int          burst_len = 0;

    always #2 i_clk = ~i_clk;

    qbu_verify_top uut (.*);

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    verify_state_t m_state;
    logic        m_r_start;
    logic        m_r_clear;
    logic        m_r_enable;
    logic        m_ver_seen;
    logic        m_res_seen;
    logic        m_v_det;
    logic        m_r_det;
    logic        m_preempt;
    logic [15:0] m_err_cnt;
    int          m_send_cnt;
    int          m_retries;
    int          m_wait_cnt;
    int          m_wait_ms;
    logic        m_sending;
    logic        m_send_last;
    logic        m_expired;
    logic [7:0]  m_smd;

    assign m_sending   = (m_state == SEND_VER) || (m_state == SEND_RES);
    assign m_send_last = m_sending && (m_send_cnt == 59);
    // expiry on the last cycle of the programmed interval in WAIT
    assign m_expired   = (m_state == WAIT) && (m_wait_cnt == m_wait_ms * CYCLES_PER_MS - 1);
    assign m_smd       = (m_state == SEND_VER) ? 8'h07 :
                         (m_state == SEND_RES) ? 8'h19 : 8'h00;

    always @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            m_state    <= IDLE;
            m_r_start  <= 1'b0;
            m_r_clear  <= 1'b0;
            m_r_enable <= 1'b0;
            m_ver_seen <= 1'b0;
            m_res_seen <= 1'b0;
            m_v_det    <= 1'b0;
            m_r_det    <= 1'b0;
            m_preempt  <= 1'b0;
            m_err_cnt  <= '0;
            m_send_cnt <= 0;
            m_retries  <= 0;
            m_wait_cnt <= 0;
            m_wait_ms  <= 10;
        end else begin
            // control inputs pass one register stage
            m_r_start  <= i_start_verify;
            m_r_clear  <= i_clear_verify;
            m_r_enable <= i_verify_enabled;
            m_v_det    <= i_v_rx_valid && i_v_rx_last && v_frame_good;
            m_r_det    <= i_r_rx_valid && i_r_rx_last && r_frame_good;
            m_preempt  <= (m_state == SUCCESS);
            m_wait_cnt <= (m_state == WAIT) ? m_wait_cnt + 1 : 0;
            m_send_cnt <= (m_sending && !m_send_last) ? m_send_cnt + 1 : 0;
            if (i_verify_time_vld) begin
                m_wait_ms <= i_verify_time;
            end
            if (m_state == IDLE) begin
                m_ver_seen <= 1'b0;
                m_res_seen <= 1'b0;
                m_retries  <= 0;
            end else begin
                m_ver_seen <= m_ver_seen | m_v_det;
                m_res_seen <= m_res_seen | m_r_det;
            end
            case (m_state)
                IDLE: if (m_r_start && m_r_enable) m_state <= SEND_VER;
                SEND_VER: if (m_send_last) m_state <= WAIT;
                WAIT: begin
                    if (m_ver_seen) begin
                        m_state <= SEND_RES;
                    end else if (m_res_seen) begin
                        m_state <= SUCCESS;
                    end else if (m_expired && m_retries < 3) begin
                        m_state   <= SEND_VER;
                        m_retries <= m_retries + 1;
                        m_err_cnt <= m_err_cnt + 16'd1;
                    end else if (m_expired) begin
                        m_state <= FAIL;
                    end
                end
                SEND_RES: if (m_send_last) m_state <= SUCCESS;
                SUCCESS: begin
                    if (m_r_start) begin
                        m_state <= IDLE;
                    end else if (m_r_clear) begin
                        m_state <= FAIL;
                    end
                end
                FAIL: if (m_r_start && m_r_enable) m_state <= IDLE;
                default: m_state <= IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks, sampled mid-cycle where outputs are settled
    //////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] got_val);
        mismatch_errs++;
        $display("MISMATCH %s expected %h got %h at %0d ns", name, exp_val, got_val, $time);
    endtask

    task automatic report_failure(input string what);
        other_errs++;
        $display("ERROR %s at %0d ns", what, $time);
    endtask

    always @(negedge i_clk) begin
        if (!i_rst) begin
            assert (o_verify_rx_valid === m_v_det)
                else report_mismatch("o_verify_rx_valid", m_v_det, o_verify_rx_valid);
            assert (o_response_rx_valid === m_r_det)
                else report_mismatch("o_response_rx_valid", m_r_det, o_response_rx_valid);
            assert (o_tx_valid === m_sending)
                else report_mismatch("o_tx_valid", m_sending, o_tx_valid);
            assert (o_tx_last === m_send_last)
                else report_mismatch("o_tx_last", m_send_last, o_tx_last);
            assert (o_tx_smd === m_smd)
                else report_mismatch("o_tx_smd", m_smd, o_tx_smd);
            assert (o_verify_done === (m_state == SUCCESS || m_state == FAIL))
                else report_mismatch("o_verify_done", m_state == SUCCESS || m_state == FAIL,
                                     o_verify_done);
            assert (o_verify_succ === (m_state == SUCCESS))
                else report_mismatch("o_verify_succ", m_state == SUCCESS, o_verify_succ);
            assert (o_preempt_enable === m_preempt)
                else report_mismatch("o_preempt_enable", m_preempt, o_preempt_enable);
            assert (o_err_verify_cnt === m_err_cnt)
                else report_mismatch("o_err_verify_cnt", m_err_cnt, o_err_verify_cnt);
        end
    end

    // burst count and length, independent of the model
    always @(negedge i_clk) begin
        if (o_tx_valid === 1'b1) begin
            if (burst_len == 0) begin
                bursts_seen++;
            end
            burst_len++;
        end else if (burst_len != 0) begin
            assert (burst_len == 60)
                else report_mismatch("o_tx_valid burst length", 60, burst_len);
            burst_len = 0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers, all entered just after a falling edge
    //////////////////////////////////////////////////////////////////////

    function automatic int rnd_below(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    // one beat on the streams in mask, bit 0 verify, bit 1 response
    task automatic drive_beat(input logic [1:0] mask, input logic valid, input logic last,
                              input logic [7:0] data, input logic good);
        if (mask[0]) begin
            i_v_rx_valid = valid;
            i_v_rx_last  = last;
            i_v_rx_data  = data;
            v_frame_good = good;
        end
        if (mask[1]) begin
            i_r_rx_valid = valid;
            i_r_rx_last  = last;
            i_r_rx_data  = data;
            r_frame_good = good;
        end
        @(negedge i_clk);
    endtask

    // frame of len beats with random idle gaps, nonzero byte at bad_pos if >= 0
    task automatic send_frame(input logic [1:0] mask, input int len, input int bad_pos);
        logic [7:0] bad_val;
        logic       good;
        int         beat;
        bad_val    = 8'($random(seed));
        bad_val[0] = 1'b1;
        good       = (len == 60) && (bad_pos < 0);
        for (beat = 0; beat < len; beat++) begin
            // idle beats carry junk data that must be ignored
            repeat (rnd_below(3)) drive_beat(mask, 1'b0, 1'b0, 8'($random(seed)), 1'b0);
            drive_beat(mask, 1'b1, beat == len - 1, (beat == bad_pos) ? bad_val : 8'h00, good);
        end
        drive_beat(mask, 1'b0, 1'b0, 8'h00, 1'b0);
    endtask

    task automatic pulse_start(input int cycles);
        i_start_verify = 1'b1;
        repeat (cycles) @(negedge i_clk);
        i_start_verify = 1'b0;
    endtask

    task automatic wait_tx_start(input int max_cycles);
        int n;
        n = 0;
        while (o_tx_valid !== 1'b1 && n < max_cycles) begin
            @(negedge i_clk);
            n++;
        end
        assert (o_tx_valid === 1'b1) else report_failure("no transmit burst started in time");
    endtask

    task automatic wait_tx_end(input int max_cycles);
        int n;
        n = 0;
        while (o_tx_valid !== 1'b0 && n < max_cycles) begin
            @(negedge i_clk);
            n++;
        end
        assert (o_tx_valid === 1'b0) else report_failure("transmit burst did not end in time");
    endtask

    task automatic wait_done(input int max_cycles);
        int n;
        n = 0;
        while (o_verify_done !== 1'b1 && n < max_cycles) begin
            @(negedge i_clk);
            n++;
        end
        assert (o_verify_done === 1'b1) else report_failure("handshake did not complete in time");
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int err_before;
        int bursts_before;
        i_rst             = 1'b1;
        i_v_rx_data       = '0;
        i_v_rx_last       = 1'b0;
        i_v_rx_valid      = 1'b0;
        i_r_rx_data       = '0;
        i_r_rx_last       = 1'b0;
        i_r_rx_valid      = 1'b0;
        i_verify_enabled  = 1'b0;
        i_start_verify    = 1'b0;
        i_clear_verify    = 1'b0;
        i_verify_time     = '0;
        i_verify_time_vld = 1'b0;
        v_frame_good      = 1'b0;
        r_frame_good      = 1'b0;
        repeat (10) @(negedge i_clk);
        i_rst = 1'b0;

        // 1 ms wait interval
        i_verify_time     = 16'd1;
        i_verify_time_vld = 1'b1;
        @(negedge i_clk);
        i_verify_time_vld = 1'b0;
        i_verify_enabled  = 1'b1;

        // detection in IDLE, good, short, long and dirty frames
        send_frame(2'b01, 60, -1);
        send_frame(2'b10, 60, -1);
        send_frame(2'b01, 1 + rnd_below(59), -1);
        send_frame(2'b10, 61 + rnd_below(3), -1);
        // long enough to wrap a 6-bit beat count back to 59
        send_frame(2'b01, 124, -1);
        send_frame(2'b01, 60, rnd_below(60));
        send_frame(2'b10, 60, 59);

        // verify burst answered by a response frame
        err_before = o_err_verify_cnt;
        pulse_start(1);
        wait_tx_start(10);
        wait_tx_end(100);
        send_frame(2'b10, 60, -1);
        wait_done(50);
        assert (o_verify_succ === 1'b1) else report_failure("response frame did not give success");
        assert (o_err_verify_cnt == err_before)
            else report_mismatch("o_err_verify_cnt", err_before, o_err_verify_cnt);

        // clear in SUCCESS goes to FAIL
        i_clear_verify = 1'b1;
        @(negedge i_clk);
        i_clear_verify = 1'b0;
        repeat (3) @(negedge i_clk);
        assert (o_verify_done === 1'b1 && o_verify_succ === 1'b0)
            else report_failure("clear in SUCCESS did not reach FAIL");

        // restart from FAIL, partner sends a verify frame
        pulse_start(2);
        wait_tx_start(10);
        wait_tx_end(100);
        send_frame(2'b01, 60, -1);
        wait_tx_start(10);
        assert (o_tx_smd === 8'h19) else report_mismatch("o_tx_smd", 8'h19, o_tx_smd);
        wait_tx_end(100);
        wait_done(10);
        assert (o_verify_succ === 1'b1) else report_failure("verify frame did not give success");

        // both frames in the same cycles, verify has priority
        pulse_start(2);
        wait_tx_start(10);
        wait_tx_end(100);
        send_frame(2'b11, 60, -1);
        wait_tx_start(10);
        assert (o_tx_smd === 8'h19) else report_mismatch("o_tx_smd", 8'h19, o_tx_smd);
        wait_tx_end(100);
        wait_done(10);

        // no answer at all, three resends then FAIL
        err_before    = o_err_verify_cnt;
        bursts_before = bursts_seen;
        pulse_start(2);
        wait_done(5 * CYCLES_PER_MS);
        assert (o_err_verify_cnt == err_before + 3)
            else report_mismatch("o_err_verify_cnt", err_before + 3, o_err_verify_cnt);
        assert (bursts_seen - bursts_before == 4)
            else report_mismatch("verify bursts", 4, bursts_seen - bursts_before);
        assert (o_verify_succ === 1'b0) else report_failure("timeout did not end in FAIL");

        // start with enable low stays in FAIL
        i_verify_enabled = 1'b0;
        pulse_start(2);
        repeat (10) @(negedge i_clk);
        assert (o_verify_done === 1'b1 && o_tx_valid === 1'b0)
            else report_failure("start with enable low left FAIL");
        i_verify_enabled = 1'b1;
        pulse_start(2);
        wait_tx_start(10);
        wait_tx_end(100);
        send_frame(2'b10, 60, -1);
        wait_done(50);
        repeat (5) @(negedge i_clk);

        $display("mismatches: %0d, other errors: %0d", mismatch_errs, other_errs);
        if (mismatch_errs == 0 && other_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        report_failure("watchdog expired before the tests finished");
        $display("mismatches: %0d, other errors: %0d", mismatch_errs, other_errs);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/qbu_verify_top.sv
// frame preemption verify handshake top level
// two mPacket detectors, wait timer and verify state machine

`default_nettype none

module qbu_verify_top
    import qbu_frame_pkg::*;
    import qbu_verify_pkg::*;
(
    input  wire logic         i_clk,
    input  wire logic         i_rst,
    // verify mPacket stream
    input  wire rx_byte_t     i_v_rx_data,
    input  wire logic         i_v_rx_last,
    input  wire logic         i_v_rx_valid,
    // response mPacket stream
    input  wire rx_byte_t     i_r_rx_data,
    input  wire logic         i_r_rx_last,
    input  wire logic         i_r_rx_valid,
    // control and configuration
    input  wire logic         i_verify_enabled,
    input  wire logic         i_start_verify,
    input  wire logic         i_clear_verify,
    input  wire verify_time_t i_verify_time,
    input  wire logic         i_verify_time_vld,
    // detect pulses
    output logic              o_verify_rx_valid,
    output logic              o_response_rx_valid,
    // transmit strobe
    output logic              o_tx_valid,
    output logic              o_tx_last,
    output smd_t              o_tx_smd,
    // status
    output logic              o_verify_done,
    output logic              o_verify_succ,
    output logic              o_preempt_enable,
    output err_cnt_t          o_err_verify_cnt
);

    // handshake between state machine and timer
    logic wait_run;
    logic wait_expired;

    ////////////////////////////////////////////////////////////////////
    // receive side
    ////////////////////////////////////////////////////////////////////

    verify_frame_detect u_verify_det (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_rx_data     (i_v_rx_data),
        .i_rx_last     (i_v_rx_last),
        .i_rx_valid    (i_v_rx_valid),
        .o_mpkt_detect (o_verify_rx_valid)
    );

    verify_frame_detect u_response_det (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_rx_data     (i_r_rx_data),
        .i_rx_last     (i_r_rx_last),
        .i_rx_valid    (i_r_rx_valid),
        .o_mpkt_detect (o_response_rx_valid)
    );

    ////////////////////////////////////////////////////////////////////
    // timer and control
    ////////////////////////////////////////////////////////////////////

    verify_timer u_timer (
        .i_clk             (i_clk),
        .i_rst             (i_rst),
        .i_wait_run        (wait_run),
        .i_verify_time     (i_verify_time),
        .i_verify_time_vld (i_verify_time_vld),
        .o_wait_expired    (wait_expired)
    );

    verify_fsm u_fsm (
        .i_clk            (i_clk),
        .i_rst            (i_rst),
        .i_start_verify   (i_start_verify),
        .i_clear_verify   (i_clear_verify),
        .i_verify_enabled (i_verify_enabled),
        .i_verify_rx      (o_verify_rx_valid),
        .i_response_rx    (o_response_rx_valid),
        .i_wait_expired   (wait_expired),
        .o_wait_run       (wait_run),
        .o_tx_valid       (o_tx_valid),
        .o_tx_last        (o_tx_last),
        .o_tx_smd         (o_tx_smd),
        .o_verify_done    (o_verify_done),
        .o_verify_succ    (o_verify_succ),
        .o_preempt_enable (o_preempt_enable),
        .o_err_verify_cnt (o_err_verify_cnt)
    );

endmodule

`default_nettype wire

//--- verify/verify_fsm.sv
// verify handshake state machine
// control input registers, sticky receive flags, send and retry counters
// transmit strobes, result flags, preemption enable and error count

`default_nettype none

module verify_fsm
    import qbu_frame_pkg::*;
    import qbu_verify_pkg::*;
(
    input  wire logic i_clk,
    input  wire logic i_rst,
    input  wire logic i_start_verify,
    input  wire logic i_clear_verify,
    input  wire logic i_verify_enabled,
    input  wire logic i_verify_rx,
    input  wire logic i_response_rx,
    input  wire logic i_wait_expired,
    output logic      o_wait_run,
    output logic      o_tx_valid,
    output logic      o_tx_last,
    output smd_t      o_tx_smd,
    output logic      o_verify_done,
    output logic      o_verify_succ,
    output logic      o_preempt_enable,
    output err_cnt_t  o_err_verify_cnt
);

    verify_state_t state;
    verify_state_t state_n;

    // registered control inputs
    logic          r_start;
    logic          r_clear;
    logic          r_enable;

    // partner frames seen since the last IDLE
    logic          ver_seen;
    logic          res_seen;

    mpkt_cnt_t     send_cnt;
    retry_cnt_t    retry_cnt;

    logic          sending;
    logic          send_last;
    // timeout in WAIT with retries left
    logic          wait_resend;

    ////////////////////////////////////////////////////////////////////
    // control input registers
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_start  <= 1'b0;
            r_clear  <= 1'b0;
            r_enable <= 1'b0;
        end else begin
            r_start  <= i_start_verify;
            r_clear  <= i_clear_verify;
            r_enable <= i_verify_enabled;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // state sequencing
    ////////////////////////////////////////////////////////////////////

    assign sending     = (state == SEND_VER) || (state == SEND_RES);
    assign send_last   = sending && (send_cnt == mpkt_cnt_t'(MPKT_BYTES - 1));
    assign wait_resend = (state == WAIT) && !ver_seen && !res_seen &&
                         i_wait_expired && (retry_cnt < MAX_RETRIES);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state <= IDLE;
        end else begin
            state <= state_n;
        end
    end

    always_comb begin
        state_n = state;
        case (state)
            IDLE: begin
                if (r_start && r_enable) begin
                    state_n = SEND_VER;
                end
            end
            SEND_VER: begin
                if (send_last) begin
                    state_n = WAIT;
                end
            end
            WAIT: begin
                // a received verify wins over a received response
                if (ver_seen) begin
                    state_n = SEND_RES;
                end else if (res_seen) begin
                    state_n = SUCCESS;
                end else if (wait_resend) begin
                    state_n = SEND_VER;
                end else if (i_wait_expired) begin
                    state_n = FAIL;
                end
            end
            SEND_RES: begin
                if (send_last) begin
                    state_n = SUCCESS;
                end
            end
            SUCCESS: begin
                if (r_start) begin
                    state_n = IDLE;
                end else if (r_clear) begin
                    state_n = FAIL;
                end
            end
            FAIL: begin
                if (r_start && r_enable) begin
                    state_n = IDLE;
                end
            end
            default: begin
                state_n = IDLE;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // sticky flags and counters
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            ver_seen <= 1'b0;
            res_seen <= 1'b0;
        end else if (state == IDLE) begin
            ver_seen <= 1'b0;
            res_seen <= 1'b0;
        end else begin
            ver_seen <= ver_seen | i_verify_rx;
            res_seen <= res_seen | i_response_rx;
        end
    end

    // byte position of the mPacket being sent
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            send_cnt <= '0;
        end else if (sending && !send_last) begin
            send_cnt <= send_cnt + mpkt_cnt_t'(1);
        end else begin
            send_cnt <= '0;
        end
    end

    // retries per attempt, restart from IDLE
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            retry_cnt <= '0;
        end else if (state == IDLE) begin
            retry_cnt <= '0;
        end else if (wait_resend) begin
            retry_cnt <= retry_cnt + retry_cnt_t'(1);
        end
    end

    // resend total, only reset clears it
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_err_verify_cnt <= '0;
        end else if (wait_resend) begin
            o_err_verify_cnt <= o_err_verify_cnt + err_cnt_t'(1);
        end
    end

    ////////////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_preempt_enable <= 1'b0;
        end else begin
            o_preempt_enable <= (state == SUCCESS);
        end
    end

    assign o_wait_run    = (state == WAIT);
    assign o_tx_valid    = sending;
    assign o_tx_last     = send_last;
    assign o_verify_done = (state == SUCCESS) || (state == FAIL);
    assign o_verify_succ = (state == SUCCESS);

    // SMD only during a send burst
    always_comb begin
        case (state)
            SEND_VER: o_tx_smd = SMD_VERIFY;
            SEND_RES: o_tx_smd = SMD_RESPONSE;
            default:  o_tx_smd = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- verify/verify_timer.sv
// verify wait timer
// loadable wait interval, cascaded clock, microsecond and millisecond counters
// expiry pulse each time the programmed interval completes

`default_nettype none

module verify_timer
    import qbu_verify_pkg::*;
(
    input  wire logic         i_clk,
    input  wire logic         i_rst,
    input  wire logic         i_wait_run,
    input  wire verify_time_t i_verify_time,
    input  wire logic         i_verify_time_vld,
    output logic              o_wait_expired
);

    // programmed interval and its last millisecond index
    verify_time_t wait_time;
    verify_time_t wait_last;

    clk_cnt_t     clk_cnt;
    us_cnt_t      us_cnt;
    verify_time_t ms_cnt;

    // end of a microsecond and of a millisecond
    logic         us_tick;
    logic         ms_tick;

    ////////////////////////////////////////////////////////////////////
    // wait interval register
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            wait_time <= VERIFY_TIME_DEFAULT;
        end else if (i_verify_time_vld) begin
            wait_time <= i_verify_time;
        end
    end

    assign wait_last = wait_time - verify_time_t'(1);

    ////////////////////////////////////////////////////////////////////
    // counter cascade
    ////////////////////////////////////////////////////////////////////

    assign us_tick        = i_wait_run && (clk_cnt == clk_cnt_t'(CLKS_PER_US - 1));
    assign ms_tick        = us_tick && (us_cnt == us_cnt_t'(US_PER_MS - 1));
    // N ms after run rises, on the last clock of the interval
    assign o_wait_expired = ms_tick && (ms_cnt == wait_last);

    // all three counters hold zero while not running
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            clk_cnt <= '0;
            us_cnt  <= '0;
            ms_cnt  <= '0;
        end else if (!i_wait_run) begin
            clk_cnt <= '0;
            us_cnt  <= '0;
            ms_cnt  <= '0;
        end else begin
            // clocks within a microsecond
            clk_cnt <= us_tick ? '0 : clk_cnt + clk_cnt_t'(1);
            // microseconds within a millisecond
            if (ms_tick) begin
                us_cnt <= '0;
            end else if (us_tick) begin
                us_cnt <= us_cnt + us_cnt_t'(1);
            end
            // milliseconds, wrap at expiry so the interval repeats
            if (o_wait_expired) begin
                ms_cnt <= '0;
            end else if (ms_tick) begin
                ms_cnt <= ms_cnt + verify_time_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

//--- source/verify_frame_detect.sv
// all-zero mPacket detector for one receive byte stream
// pulses once after the last beat of a 60-byte frame of zero bytes

`default_nettype none

module verify_frame_detect
    import qbu_frame_pkg::*;
(
    input  wire logic     i_clk,
    input  wire logic     i_rst,
    input  wire rx_byte_t i_rx_data,
    input  wire logic     i_rx_last,
    input  wire logic     i_rx_valid,
    output logic          o_mpkt_detect
);

    // beats already taken in the current frame
    mpkt_cnt_t beat_cnt;
    // some earlier byte of this frame was not zero
    logic      nonzero;
    // current beat closes a qualifying frame
    logic      frame_ok;

    // sixtieth beat, zero itself, and nothing nonzero before it
    assign frame_ok = i_rx_valid && i_rx_last &&
                      (beat_cnt == mpkt_cnt_t'(MPKT_BYTES - 1)) &&
                      !nonzero && (i_rx_data == '0);

    // beat count and nonzero flag, both restart after a last beat
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            beat_cnt <= '0;
            nonzero  <= 1'b0;
        end else if (i_rx_valid && i_rx_last) begin
            beat_cnt <= '0;
            nonzero  <= 1'b0;
        end else if (i_rx_valid) begin
            // saturate so long frames never alias to 60
            if (beat_cnt != '1) begin
                beat_cnt <= beat_cnt + mpkt_cnt_t'(1);
            end
            nonzero <= nonzero | (i_rx_data != '0);
        end
    end

    // one-cycle detect pulse, the cycle after the last beat
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_mpkt_detect <= 1'b0;
        end else begin
            o_mpkt_detect <= frame_ok;
        end
    end

endmodule

`default_nettype wire

//--- common/qbu_verify_pkg.sv
// verify handshake control definitions
// state enum, timer and counter types, clock rate, retry limit, wait default

`default_nettype none

package qbu_verify_pkg;

    ////////////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        // waiting for a start request
        IDLE,
        // sending our own verify mPacket
        SEND_VER,
        // waiting for the partner's answer
        WAIT,
        // answering a received verify
        SEND_RES,
        // handshake done, preemption allowed
        SUCCESS,
        // retries used up or cleared
        FAIL
    } verify_state_t;

    ////////////////////////////////////////////////////////////////////
    // timer and counter types
    ////////////////////////////////////////////////////////////////////

    // wait interval, unit is one millisecond
    typedef logic [15:0] verify_time_t;

    // clocks inside one microsecond
    typedef logic [6:0] clk_cnt_t;

    // microseconds inside one millisecond
    typedef logic [9:0] us_cnt_t;

    // total resends since reset
    typedef logic [15:0] err_cnt_t;

    // resends in the current attempt
    typedef logic [1:0] retry_cnt_t;

    ////////////////////////////////////////////////////////////////////
    // constants
    ////////////////////////////////////////////////////////////////////

    // 125 MHz core clock
    localparam int CLKS_PER_US = 125;
    localparam int US_PER_MS   = 1000;

    // resends allowed before giving up
    localparam retry_cnt_t MAX_RETRIES = 2'd3;

    // wait interval after reset, in ms
    localparam verify_time_t VERIFY_TIME_DEFAULT = 16'd10;

endpackage

`default_nettype wire

//--- common/qbu_frame_pkg.sv
// mPacket framing definitions for the frame preemption verify handshake
// byte and SMD types, mPacket length, verify and response SMD codes

`default_nettype none

package qbu_frame_pkg;

    ////////////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////////////

    // one byte of a receive stream
    typedef logic [7:0] rx_byte_t;

    // start-of-mPacket delimiter
    typedef logic [7:0] smd_t;

    // beat position inside one mPacket, holds 0..63
    typedef logic [5:0] mpkt_cnt_t;

    ////////////////////////////////////////////////////////////////////
    // constants
    ////////////////////////////////////////////////////////////////////

    // verify and response mPackets carry 60 zero bytes
    localparam int MPKT_BYTES = 60;

    // SMD-V, sent when asking the link partner to verify
    localparam smd_t SMD_VERIFY = 8'h07;

    // SMD-R, sent as the answer to a received verify
    localparam smd_t SMD_RESPONSE = 8'h19;

endpackage

`default_nettype wire
